// File: build.f
+incdir+verif
rtl/busPkg.sv
rtl/boardPkg.sv
rtl/panelInput.sv
rtl/intervalTimer.sv
rtl/portRegFile.sv
rtl/debugDisplay.sv
rtl/boardTop.sv
verif/boardTb.sv

// File: rtl/boardPkg.sv
package boardPkg;

   localparam int numBtn = 4;
   localparam int numSw  = 8;

   // panel state after synchronization
   typedef struct packed {
      logic [numBtn-1:0] btn;
      logic [numSw-1:0]  sw;
      logic [numBtn-1:0] btnRise;
   } panelSample;

   // debug display sources
   localparam logic [3:0] dispPortA   = 4'd0;
   localparam logic [3:0] dispPortB   = 4'd1;
   localparam logic [3:0] dispPortC   = 4'd2;
   localparam logic [3:0] dispPortD   = 4'd3;
   localparam logic [3:0] dispTmr     = 4'd4;
   localparam logic [3:0] dispArr     = 4'd5;
   localparam logic [3:0] dispCtr     = 4'd6;
   localparam logic [3:0] dispIrqStat = 4'd7;
   localparam logic [3:0] dispPortI   = 4'd8;
   localparam logic [3:0] dispPortJ   = 4'd9;
   localparam logic [3:0] dispIrqEn   = 4'd10;

   // timer values shared with register file and display
   typedef struct packed {
      logic [31:0] tmr;
      logic [31:0] arr;
      logic [31:0] ctr;
      logic        arReached;
   } timerState;

endpackage

// File: rtl/boardTop.sv
`timescale 1ns/1ps

module boardTop import busPkg::*, boardPkg::*;
(
   input  logic              f100Hz,
   input  logic              rstN,
   input  logic [numSw-1:0]  sw,
   input  logic [numBtn-1:0] btn,
   input  apbReq             req,
   output apbRsp             rsp,
   output logic [3:0]        led,
   output logic [31:0]       displayData,
   output logic              irq
);

   panelSample  sample;
   timerState   timer;
   tmrCtrlWord  tmrCtrl;
   logic [31:0] arr;
   logic [31:0] portA;
   logic [31:0] portB;
   logic [31:0] portC;
   logic [31:0] portD;
   logic [31:0] irqStat;
   logic [31:0] irqEn;

   // input side
   panelInput panel0 (
      .f100Hz (f100Hz),
      .rstN   (rstN),
      .sw     (sw),
      .btn    (btn),
      .sample (sample)
   );

   portRegFile regs0 (
      .f100Hz  (f100Hz),
      .rstN    (rstN),
      .req     (req),
      .rsp     (rsp),
      .sample  (sample),
      .timer   (timer),
      .portA   (portA),
      .portB   (portB),
      .portC   (portC),
      .portD   (portD),
      .tmrCtrl (tmrCtrl),
      .arr     (arr),
      .irqStat (irqStat),
      .irqEn   (irqEn),
      .irq     (irq)
   );

   intervalTimer timer0 (
      .f100Hz (f100Hz),
      .rstN   (rstN),
      .ctrl   (tmrCtrl),
      .arr    (arr),
      .state  (timer)
   );

   // LEDs and debug display
   debugDisplay disp0 (
      .f100Hz      (f100Hz),
      .rstN        (rstN),
      .sample      (sample),
      .portA       (portA),
      .portB       (portB),
      .portC       (portC),
      .portD       (portD),
      .irqStat     (irqStat),
      .irqEn       (irqEn),
      .timer       (timer),
      .led         (led),
      .displayData (displayData)
   );

endmodule

// File: rtl/busPkg.sv
package busPkg;

   // APB request, driven by the CPU side
   typedef struct packed {
      logic        psel;
      logic        penable;
      logic        pwrite;
      logic [7:0]  paddr;
      logic [31:0] pwdata;
   } apbReq;

   typedef struct packed {
      logic [31:0] prdata;
      logic        pready;
      logic        pslverr;
   } apbRsp;

   // register map
   localparam logic [7:0] addrPortA   = 8'h00;
   localparam logic [7:0] addrPortB   = 8'h04;
   localparam logic [7:0] addrPortC   = 8'h08;
   localparam logic [7:0] addrPortD   = 8'h0C;
   localparam logic [7:0] addrPortI   = 8'h10;
   localparam logic [7:0] addrPortJ   = 8'h14;
   localparam logic [7:0] addrTmrCtrl = 8'h18;
   localparam logic [7:0] addrArr     = 8'h1C;
   localparam logic [7:0] addrTmr     = 8'h20;
   localparam logic [7:0] addrCtr     = 8'h24;
   localparam logic [7:0] addrIrqStat = 8'h28;
   localparam logic [7:0] addrIrqEn   = 8'h2C;

   // timer control, field view
   typedef struct packed {
      logic [29:0] reserved;
      logic        clearCount;
      logic        run;
   } tmrCtrlFields;

   typedef union packed {
      logic [31:0]  raw;
      tmrCtrlFields fields;
   } tmrCtrlWord;

   // interrupt bit positions
   localparam int irqTimerBit = 0;
   localparam int irqBtnLsb   = 4;

endpackage

// File: rtl/debugDisplay.sv
`timescale 1ns/1ps

module debugDisplay import boardPkg::*;
(
   input  logic        f100Hz,
   input  logic        rstN,
   input  panelSample  sample,
   input  logic [31:0] portA,
   input  logic [31:0] portB,
   input  logic [31:0] portC,
   input  logic [31:0] portD,
   input  logic [31:0] irqStat,
   input  logic [31:0] irqEn,
   input  timerState   timer,
   output logic [3:0]  led,
   output logic [31:0] displayData
);

   logic [3:0]  dispSel;
   logic [31:0] dispNext;

   // upper switch nibble picks the source
   assign dispSel = sample.sw[7:4];

   always_comb
   begin
      case (dispSel)
         dispPortA:   dispNext = portA;
         dispPortB:   dispNext = portB;
         dispPortC:   dispNext = portC;
         dispPortD:   dispNext = portD;
         dispTmr:     dispNext = timer.tmr;
         dispArr:     dispNext = timer.arr;
         dispCtr:     dispNext = timer.ctr;
         dispIrqStat: dispNext = irqStat;
         dispPortI:   dispNext = 32'(sample.btn);
         dispPortJ:   dispNext = 32'(sample.sw);
         dispIrqEn:   dispNext = irqEn;
         default:     dispNext = '0;
      endcase
   end

   always_ff @(posedge f100Hz)
   begin
      if (!rstN)
      begin
         displayData <= '0;
         led         <= '0;
      end
      else
      begin
         displayData <= dispNext;
         led         <= portB[3:0];
      end
   end

endmodule

// File: rtl/intervalTimer.sv
`timescale 1ns/1ps

module intervalTimer import busPkg::*, boardPkg::*;
(
   input  logic        f100Hz,
   input  logic        rstN,
   input  tmrCtrlWord  ctrl,
   input  logic [31:0] arr,
   output timerState   state
);

   logic [31:0] tmr;
   logic [31:0] ctr;
   logic        run;
   logic        clearCount;
   logic        reached;

   // field view of the control word
   assign run        = ctrl.fields.run;
   assign clearCount = ctrl.fields.clearCount;

   // reload when the count hits arr
   assign reached = run && !clearCount && (tmr == arr);

   always_ff @(posedge f100Hz)
   begin
      if (!rstN)
      begin
         tmr <= '0;
         ctr <= '0;
      end
      else if (clearCount)
      begin
         tmr <= '0;
         ctr <= '0;
      end
      else if (reached)
      begin
         tmr <= '0;
         ctr <= ctr + 32'd1;
      end
      else if (run)
      begin
         tmr <= tmr + 32'd1;
      end
   end

   assign state.tmr       = tmr;
   assign state.arr       = arr;
   assign state.ctr       = ctr;
   assign state.arReached = reached;

endmodule

// File: rtl/panelInput.sv
`timescale 1ns/1ps

module panelInput import boardPkg::*;
(
   input  logic              f100Hz,
   input  logic              rstN,
   input  logic [numSw-1:0]  sw,
   input  logic [numBtn-1:0] btn,
   output panelSample        sample
);

   logic [numSw-1:0]  swMeta;
   logic [numSw-1:0]  swSync;
   logic [numBtn-1:0] btnMeta;
   logic [numBtn-1:0] btnSync;
   logic [numBtn-1:0] btnPrev;

   // two flop stages per pin, plus last button value
   always_ff @(posedge f100Hz)
   begin
      if (!rstN)
      begin
         swMeta  <= '0;
         swSync  <= '0;
         btnMeta <= '0;
         btnSync <= '0;
         btnPrev <= '0;
      end
      else
      begin
         swMeta  <= sw;
         swSync  <= swMeta;
         btnMeta <= btn;
         btnSync <= btnMeta;
         btnPrev <= btnSync;
      end
   end

   assign sample.sw  = swSync;
   assign sample.btn = btnSync;

   // one cycle per press
   assign sample.btnRise = btnSync & ~btnPrev;

endmodule

// File: rtl/portRegFile.sv
`timescale 1ns/1ps

module portRegFile import busPkg::*, boardPkg::*;
(
   input  logic        f100Hz,
   input  logic        rstN,
   input  apbReq       req,
   output apbRsp       rsp,
   input  panelSample  sample,
   input  timerState   timer,
   output logic [31:0] portA,
   output logic [31:0] portB,
   output logic [31:0] portC,
   output logic [31:0] portD,
   output tmrCtrlWord  tmrCtrl,
   output logic [31:0] arr,
   output logic [31:0] irqStat,
   output logic [31:0] irqEn,
   output logic        irq
);

   logic        access;
   logic        readOnly;
   logic        unmapped;
   logic        err;
   logic        wrEn;
   logic [31:0] rdData;
   logic [31:0] irqSet;
   logic [31:0] irqClr;
   tmrCtrlWord  wrCtrl;

   assign access = req.psel && req.penable;

   // address decode and read mux
   always_comb
   begin
      readOnly = 1'b0;
      unmapped = 1'b0;
      rdData   = '0;
      case (req.paddr)
         addrPortA:   rdData = portA;
         addrPortB:   rdData = portB;
         addrPortC:   rdData = portC;
         addrPortD:   rdData = portD;
         addrPortI:
         begin
            rdData   = 32'(sample.btn);
            readOnly = 1'b1;
         end
         addrPortJ:
         begin
            rdData   = 32'(sample.sw);
            readOnly = 1'b1;
         end
         addrTmrCtrl: rdData = tmrCtrl.raw;
         addrArr:     rdData = arr;
         addrTmr:
         begin
            rdData   = timer.tmr;
            readOnly = 1'b1;
         end
         addrCtr:
         begin
            rdData   = timer.ctr;
            readOnly = 1'b1;
         end
         addrIrqStat: rdData = irqStat;
         addrIrqEn:   rdData = irqEn;
         default:     unmapped = 1'b1;
      endcase
   end

   assign err  = access && (unmapped || (req.pwrite && readOnly));
   assign wrEn = access && req.pwrite && !err;

   // zero wait states, every access completes
   assign rsp.pready  = access;
   assign rsp.pslverr = err;
   assign rsp.prdata  = rdData;

   assign wrCtrl.raw = req.pwdata;

   // timer and button events
   always_comb
   begin
      irqSet = '0;
      irqSet[irqTimerBit] = timer.arReached;
      irqSet[irqBtnLsb +: numBtn] = sample.btnRise;
   end

   assign irqClr = (wrEn && req.paddr == addrIrqStat) ? req.pwdata : '0;

   always_ff @(posedge f100Hz)
   begin
      if (!rstN)
      begin
         portA       <= '0;
         portB       <= '0;
         portC       <= '0;
         portD       <= '0;
         tmrCtrl.raw <= '0;
         arr         <= '0;
         irqStat     <= '0;
         irqEn       <= '0;
      end
      else
      begin
         // clearCount lasts a single cycle
         tmrCtrl.fields.clearCount <= 1'b0;
         if (wrEn)
         begin
            case (req.paddr)
               addrPortA:   portA <= req.pwdata;
               addrPortB:   portB <= req.pwdata;
               addrPortC:   portC <= req.pwdata;
               addrPortD:   portD <= req.pwdata;
               addrTmrCtrl:
               begin
                  tmrCtrl.fields.run        <= wrCtrl.fields.run;
                  tmrCtrl.fields.clearCount <= wrCtrl.fields.clearCount;
               end
               addrArr:     arr   <= req.pwdata;
               addrIrqEn:   irqEn <= req.pwdata;
               default:     ;
            endcase
         end
         // a new event beats a clear
         irqStat <= (irqStat & ~irqClr) | irqSet;
      end
   end

   assign irq = |(irqStat & irqEn);

endmodule

// File: verif/boardTbTasks.svh
`ifndef BOARD_TB_TASKS_SVH
`define BOARD_TB_TASKS_SVH

task automatic stopRun();
   $display("tests failed");
   $fatal(1);
endtask

task automatic checkEq(input logic [31:0] got, input logic [31:0] exp, input string what);
   if (got !== exp)
   begin
      $display("MISMATCH at %0t: %s, got %h, expected %h", $time, what, got, exp);
      stopRun();
   end
endtask

// one APB transfer, called and returning on a falling edge
task automatic apbTransfer(input logic write, input logic [7:0] addr,
                           input logic [31:0] wdata, output logic [31:0] rdata,
                           output logic err);
   integer n;
   req.psel    = 1'b1;
   req.penable = 1'b0;
   req.pwrite  = write;
   req.paddr   = addr;
   req.pwdata  = wdata;
   #1;
   // no completion during the setup cycle
   checkEq(rsp.pready, 0, "pready in setup cycle");
   @(negedge f100Hz);
   req.penable = 1'b1;
   n = 0;
   #1;
   while (rsp.pready !== 1'b1)
   begin
      if (n >= apbTimeout)
      begin
         $display("timeout: APB access to address %h never saw pready", addr);
         stopRun();
      end
      @(negedge f100Hz);
      #1;
      n = n + 1;
   end
   rdata = rsp.prdata;
   err   = rsp.pslverr;
   @(negedge f100Hz);
   req.psel    = 1'b0;
   req.penable = 1'b0;
   req.pwrite  = 1'b0;
endtask

task automatic regWrite(input logic [7:0] addr, input logic [31:0] data);
   logic [31:0] unused;
   logic        err;
   apbTransfer(1'b1, addr, data, unused, err);
   checkEq(err, 0, "pslverr on a legal write");
endtask

task automatic regRead(input logic [7:0] addr, output logic [31:0] data);
   logic err;
   apbTransfer(1'b0, addr, 32'd0, data, err);
   checkEq(err, 0, "pslverr on a legal read");
endtask

// fixed delays, only where the latency is known
task automatic waitCycles(input integer n);
   repeat (n) @(negedge f100Hz);
endtask

task automatic waitForIrq(input integer limit, input string what);
   integer n;
   n = 0;
   while (irq !== 1'b1)
   begin
      if (n >= limit)
      begin
         $display("timeout: irq did not rise while waiting for %s", what);
         stopRun();
      end
      @(negedge f100Hz);
      n = n + 1;
   end
endtask

`endif

// File: verif/boardTb.sv
`timescale 1ns/1ps

module boardTb import busPkg::*, boardPkg::*;
();

   localparam integer apbTimeout = 8;

   logic              f100Hz;
   logic              rstN;
   logic [numSw-1:0]  sw;
   logic [numBtn-1:0] btn;
   apbReq             req;
   apbRsp             rsp;
   logic [3:0]        led;
   logic [31:0]       displayData;
   logic              irq;

   integer      seed;
   logic [31:0] modelPort [4];
   logic [31:0] modelArr;
   logic [31:0] modelIrqEn;
   logic [31:0] modelIrqStat;
   logic [31:0] rd;
   logic [31:0] data;
   logic [31:0] c1;
   logic [31:0] c2;
   logic        err;
   logic        irqNow;
   logic [3:0]  newBtn;
   integer      i;
   integer      b;
   integer      o;

   boardTop dut0 (
      .f100Hz      (f100Hz),
      .rstN        (rstN),
      .sw          (sw),
      .btn         (btn),
      .req         (req),
      .rsp         (rsp),
      .led         (led),
      .displayData (displayData),
      .irq         (irq)
   );

   `include "boardTbTasks.svh"

   always #50 f100Hz = ~f100Hz;

   // expected display source, timer has not run yet
   function automatic logic [31:0] expectedDisplay(input logic [3:0] sel);
      case (sel)
         4'd0, 4'd1, 4'd2, 4'd3: return modelPort[sel[1:0]];
         4'd5:  return modelArr;
         4'd7:  return modelIrqStat;
         4'd8:  return 32'(btn);
         4'd9:  return 32'(sw);
         4'd10: return modelIrqEn;
         default: return 32'd0;
      endcase
   endfunction

   initial
   begin
      seed   = 32'he9c0e9e6;
      f100Hz = 1'b0;
      rstN   = 1'b0;
      sw     = '0;
      btn    = '0;
      req    = '0;
      for (i = 0; i < 4; i = i + 1)
         modelPort[i] = '0;
      modelArr     = '0;
      modelIrqEn   = '0;
      modelIrqStat = '0;
      waitCycles(8);
      rstN = 1'b1;
      waitCycles(1);
      checkEq(led, 0, "led after reset");
      checkEq(displayData, 0, "displayData after reset");
      checkEq(irq, 0, "irq after reset");
      checkEq(rsp.pready, 0, "pready after reset");
      checkEq(rsp.pslverr, 0, "pslverr after reset");

      // ports A to D and led
      for (i = 0; i < 20; i = i + 1)
      begin
         b    = $random(seed) & 3;
         data = $random(seed);
         regWrite(8'(4 * b), data);
         modelPort[b] = data;
         regRead(8'(4 * b), rd);
         checkEq(rd, modelPort[b], "port readback");
         checkEq(led, modelPort[1][3:0], "led from port B");
      end
      // read-only and unmapped writes
      apbTransfer(1'b1, addrPortI, $random(seed), rd, err);
      checkEq(err, 1, "pslverr on port I write");
      apbTransfer(1'b1, addrPortJ, $random(seed), rd, err);
      checkEq(err, 1, "pslverr on port J write");
      apbTransfer(1'b1, addrTmr, $random(seed), rd, err);
      checkEq(err, 1, "pslverr on tmr write");
      apbTransfer(1'b1, addrCtr, $random(seed), rd, err);
      checkEq(err, 1, "pslverr on ctr write");
      apbTransfer(1'b1, 8'h30, $random(seed), rd, err);
      checkEq(err, 1, "pslverr on unmapped write");
      apbTransfer(1'b1, 8'h05, $random(seed), rd, err);
      checkEq(err, 1, "pslverr on unaligned write");
      apbTransfer(1'b0, 8'h3C, 32'd0, rd, err);
      checkEq(err, 1, "pslverr on unmapped read");
      for (i = 0; i < 4; i = i + 1)
      begin
         regRead(8'(4 * i), rd);
         checkEq(rd, modelPort[i], "port after rejected writes");
      end

      // switches and buttons through ports J and I
      for (i = 0; i < 8; i = i + 1)
      begin
         newBtn = $random(seed);
         modelIrqStat = modelIrqStat | (32'(newBtn & ~btn) << irqBtnLsb);
         btn = newBtn;
         sw  = $random(seed);
         waitCycles(3);
         regRead(addrPortJ, rd);
         checkEq(rd, 32'(sw), "port J");
         regRead(addrPortI, rd);
         checkEq(rd, 32'(btn), "port I");
      end

      // display mux, timer stopped
      modelArr   = $random(seed);
      modelIrqEn = $random(seed);
      regWrite(addrArr, modelArr);
      regWrite(addrIrqEn, modelIrqEn);
      for (i = 0; i < 16; i = i + 1)
      begin
         sw = {4'(i), 4'($random(seed))};
         waitCycles(4);
         checkEq(displayData, expectedDisplay(4'(i)), "displayData for selector");
         checkEq(irq, |(modelIrqStat & modelIrqEn), "irq from status and enable");
      end

      // timer reload interrupt
      regWrite(addrIrqStat, 32'hFFFF_FFFF);
      modelIrqStat = '0;
      modelIrqEn   = 32'd1;
      regWrite(addrIrqEn, modelIrqEn);
      modelArr = 16 + ($random(seed) & 15);
      regWrite(addrArr, modelArr);
      regWrite(addrTmrCtrl, 32'd1);
      waitForIrq(4 * (modelArr + 2), "the first timer reload");
      regRead(addrIrqStat, rd);
      checkEq(rd[irqTimerBit], 1, "timer status bit");
      regRead(addrCtr, c1);
      checkEq(c1 >= 1, 1, "ctr counted a reload");
      regRead(addrTmr, rd);
      checkEq(rd <= modelArr, 1, "tmr within arr");
      regWrite(addrIrqStat, 32'd1);
      irqNow = irq;
      regRead(addrCtr, c2);
      // only meaningful if no reload slipped in
      if (c2 == c1)
         checkEq(irqNow, 0, "irq after clearing timer status");
      regWrite(addrTmrCtrl, 32'd3);
      regRead(addrCtr, rd);
      checkEq(rd, 0, "ctr after clearCount");
      regRead(addrTmrCtrl, rd);
      checkEq(rd, 1, "clearCount self-clears");
      regWrite(addrTmrCtrl, 32'd0);

      // button interrupts
      btn = '0;
      waitCycles(3);
      regWrite(addrIrqStat, 32'hFFFF_FFFF);
      b = $random(seed) & 3;
      modelIrqEn = 32'd1 << (irqBtnLsb + b);
      regWrite(addrIrqEn, modelIrqEn);
      btn = 4'd1 << b;
      waitForIrq(10, "an enabled button press");
      regRead(addrIrqStat, rd);
      checkEq(rd, modelIrqEn, "status after enabled press");
      regWrite(addrIrqStat, modelIrqEn);
      checkEq(irq, 0, "irq after clearing button status");
      btn = '0;
      waitCycles(4);
      regRead(addrIrqStat, rd);
      checkEq(rd, 0, "status after release");
      o = (b + 1 + (($random(seed) & 32'h7FFF_FFFF) % 3)) & 3;
      btn = 4'd1 << o;
      waitCycles(4);
      regRead(addrIrqStat, rd);
      checkEq(rd, 32'd1 << (irqBtnLsb + o), "status after masked press");
      checkEq(irq, 0, "irq stays low for masked button");

      $display("all tests passed");
      $finish;
   end

endmodule
